//--- hw/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;
	typedef logic [2:0]  aluOpT;
	typedef logic [1:0]  fwdSelT;

	// ALU codes
	localparam aluOpT aluAnd = 3'd0;
	localparam aluOpT aluOr  = 3'd1;
	localparam aluOpT aluAdd = 3'd2;
	localparam aluOpT aluSub = 3'd6;
	localparam aluOpT aluSlt = 3'd7;

	localparam fwdSelT fwdNone  = 2'd0; // Value read in decode
	localparam fwdSelT fwdExMem = 2'd1;
	localparam fwdSelT fwdMemWb = 2'd2;

	localparam int imemWords   = 64;
	localparam int dmemWords   = 64;
	localparam int memAddrBits = 6; // Word index from address bits 7:2

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opBne     = 6'h05;
	localparam logic [5:0] opAddi    = 6'h08;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;

	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	typedef struct packed {
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  aluSrcImm;
		logic  branchEq;
		logic  branchNe;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic valid;
		wordT instr;
		wordT pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT    ctrl;
		wordT    pcPlus4;
		wordT    rsData;
		wordT    rtData;
		wordT    imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT dest;
	} idExT;

	typedef struct packed {
		logic    regWrite;
		logic    memRead;
		logic    memWrite;
		logic    memToReg;
		wordT    aluResult;
		wordT    storeData;
		regAddrT dest;
	} exMemT;

	typedef struct packed {
		logic    regWrite;
		regAddrT dest;
		wordT    wData;
	} memWbT;

endpackage

//--- hw/alu.sv
`timescale 1ns/10ps

module alu import mipsPkg::*; (
	input  aluOpT op,
	input  wordT  a,
	input  wordT  b,
	output wordT  result,
	output logic  zero
);

	always_comb begin
		case (op)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluSlt:  result = {31'd0, $signed(a) < $signed(b)};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // Used by BEQ/BNE after a subtract

endmodule

//--- hw/registerFile.sv
`timescale 1ns/10ps

module registerFile import mipsPkg::*; (
	input  logic    Clk,
	input  logic    rstN,
	input  regAddrT rs,
	input  regAddrT rt,
	input  logic    we,
	input  regAddrT wAddr,
	input  wordT    wData,
	output wordT    rsData,
	output wordT    rtData
);

	wordT regs [32];

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

	// Write-through so WB and ID can share a cycle
	assign rsData = (rs == '0) ? '0 : (we && wAddr == rs) ? wData : regs[rs];
	assign rtData = (rt == '0) ? '0 : (we && wAddr == rt) ? wData : regs[rt];

endmodule

//--- hw/fetchStage.sv
`timescale 1ns/10ps

module fetchStage import mipsPkg::*; (
	input  logic Clk,
	input  logic rstN,
	input  logic stall,
	input  logic branchTaken,
	input  wordT branchTarget,
	input  logic jumpTaken,
	input  wordT jumpTarget,
	input  logic imemWe,
	input  wordT imemAddr,
	input  wordT imemData,
	output ifIdT ifId
);

	wordT pc;
	wordT pcPlus4;
	wordT instr;
	wordT imem [imemWords];

	assign pcPlus4 = pc + 32'd4;
	assign instr   = imem[pc[memAddrBits+1:2]];

	// Load port, also works while held in reset
	always_ff @(posedge Clk) begin
		if (imemWe)
			imem[imemAddr[memAddrBits+1:2]] <= imemData;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			pc <= '0;
		else if (branchTaken)
			pc <= branchTarget; // Branch beats jump and stall
		else if (jumpTaken)
			pc <= jumpTarget;
		else if (!stall)
			pc <= pcPlus4;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			ifId <= '0;
		end else if (branchTaken || jumpTaken) begin
			ifId.valid <= 1'b0; // Squash wrong-path fetch
		end else if (!stall) begin
			ifId.valid   <= 1'b1;
			ifId.instr   <= instr;
			ifId.pcPlus4 <= pcPlus4;
		end
	end

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/10ps

module decodeStage import mipsPkg::*; (
	input  logic    Clk,
	input  logic    rstN,
	input  ifIdT    ifId,
	input  logic    stall,
	input  logic    branchTaken,
	input  memWbT   memWb,
	output idExT    idEx,
	output logic    jumpTaken,
	output wordT    jumpTarget,
	output regAddrT rs,
	output regAddrT rt
);

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddrT    rd;
	ctrlT       ctrl;
	logic       rType;
	wordT       imm;
	wordT       rsData;
	wordT       rtData;

	assign opcode = ifId.instr[31:26];
	assign funct  = ifId.instr[5:0];
	assign rs     = ifId.instr[25:21];
	assign rt     = ifId.instr[20:16];
	assign rd     = ifId.instr[15:11];
	assign rType  = (opcode == opSpecial);

	// ORI zero-extends, everything else sign-extends
	assign imm = (opcode == opOri) ? {16'h0000, ifId.instr[15:0]}
		: {{16{ifId.instr[15]}}, ifId.instr[15:0]};

	assign jumpTaken  = ifId.valid && (opcode == opJ);
	assign jumpTarget = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00};

	registerFile registerFile_inst (
		.Clk    (Clk),
		.rstN   (rstN),
		.rs     (rs),
		.rt     (rt),
		.we     (memWb.regWrite),
		.wAddr  (memWb.dest),
		.wData  (memWb.wData),
		.rsData (rsData),
		.rtData (rtData)
	);

	always_comb begin
		ctrl = '0;
		if (ifId.valid) begin
			case (opcode)
				opSpecial: begin
					ctrl.regWrite = 1'b1;
					case (funct)
						fnAdd, fnAddu: ctrl.aluOp = aluAdd;
						fnSub, fnSubu: ctrl.aluOp = aluSub;
						fnAnd:         ctrl.aluOp = aluAnd;
						fnOr:          ctrl.aluOp = aluOr;
						fnSlt:         ctrl.aluOp = aluSlt;
						default:       ctrl = '0; // Unknown function
					endcase
				end
				opAddi, opAddiu: begin
					ctrl.regWrite  = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp     = aluAdd;
				end
				opOri: begin
					ctrl.regWrite  = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp     = aluOr;
				end
				opLw: begin
					ctrl.regWrite  = 1'b1;
					ctrl.memRead   = 1'b1;
					ctrl.memToReg  = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp     = aluAdd;
				end
				opSw: begin
					ctrl.memWrite  = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp     = aluAdd;
				end
				opBeq: begin
					ctrl.branchEq = 1'b1;
					ctrl.aluOp    = aluSub;
				end
				opBne: begin
					ctrl.branchNe = 1'b1;
					ctrl.aluOp    = aluSub;
				end
				default: ctrl = '0; // J has no work past decode
			endcase
		end
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			idEx <= '0;
		end else begin
			idEx.ctrl    <= (stall || branchTaken) ? '0 : ctrl; // Bubble
			idEx.pcPlus4 <= ifId.pcPlus4;
			idEx.rsData  <= rsData;
			idEx.rtData  <= rtData;
			idEx.imm     <= imm;
			idEx.rs      <= rs;
			idEx.rt      <= rt;
			idEx.dest    <= rType ? rd : rt;
		end
	end

endmodule

//--- hw/executeStage.sv
`timescale 1ns/10ps

module executeStage import mipsPkg::*; (
	input  logic   Clk,
	input  logic   rstN,
	input  idExT   idEx,
	input  fwdSelT fwdA,
	input  fwdSelT fwdB,
	input  wordT   exMemFwd,
	input  wordT   wbFwd,
	output exMemT  exMem,
	output logic   branchTaken,
	output wordT   branchTarget
);

	wordT opA;
	wordT opB;
	wordT aluB;
	wordT aluResult;
	logic zero;

	always_comb begin
		case (fwdA)
			fwdExMem: opA = exMemFwd;
			fwdMemWb: opA = wbFwd;
			default:  opA = idEx.rsData;
		endcase
		case (fwdB)
			fwdExMem: opB = exMemFwd;
			fwdMemWb: opB = wbFwd;
			default:  opB = idEx.rtData;
		endcase
	end

	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

	alu alu_inst (
		.op     (idEx.ctrl.aluOp),
		.a      (opA),
		.b      (aluB),
		.result (aluResult),
		.zero   (zero)
	);

	assign branchTaken  = (idEx.ctrl.branchEq & zero) | (idEx.ctrl.branchNe & ~zero);
	assign branchTarget = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			exMem <= '0;
		end else begin
			exMem.regWrite  <= idEx.ctrl.regWrite;
			exMem.memRead   <= idEx.ctrl.memRead;
			exMem.memWrite  <= idEx.ctrl.memWrite;
			exMem.memToReg  <= idEx.ctrl.memToReg;
			exMem.aluResult <= aluResult;
			exMem.storeData <= opB; // Forwarded rt
			exMem.dest      <= idEx.dest;
		end
	end

endmodule

//--- hw/memoryStage.sv
`timescale 1ns/10ps

module memoryStage import mipsPkg::*; (
	input  logic  Clk,
	input  logic  rstN,
	input  exMemT exMem,
	output memWbT memWb,
	output logic  memWe,
	output wordT  memAddr,
	output wordT  memData
);

	wordT dmem [dmemWords];
	wordT loadData;

	assign memWe    = exMem.memWrite;
	assign memAddr  = exMem.aluResult;
	assign memData  = exMem.storeData;
	assign loadData = dmem[exMem.aluResult[memAddrBits+1:2]]; // Async read

	always_ff @(posedge Clk) begin
		if (exMem.memWrite)
			dmem[exMem.aluResult[memAddrBits+1:2]] <= exMem.storeData;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			memWb <= '0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.dest     <= exMem.dest;
			memWb.wData    <= exMem.memToReg ? loadData : exMem.aluResult;
		end
	end

endmodule

//--- hw/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit import mipsPkg::*; (
	input  regAddrT rsId,
	input  regAddrT rtId,
	input  idExT    idEx,
	input  exMemT   exMem,
	input  memWbT   memWb,
	output logic    stall,
	output fwdSelT  fwdA,
	output fwdSelT  fwdB
);

	logic exMemHit;
	logic memWbHit;

	// Load in EX feeding the instruction in ID
	assign stall = idEx.ctrl.memRead && idEx.dest != '0
		&& (idEx.dest == rsId || idEx.dest == rtId);

	assign exMemHit = exMem.regWrite && !exMem.memRead && exMem.dest != '0;
	assign memWbHit = memWb.regWrite && memWb.dest != '0;

	// Newer stage wins
	always_comb begin
		fwdA = fwdNone;
		fwdB = fwdNone;
		if (exMemHit && exMem.dest == idEx.rs)
			fwdA = fwdExMem;
		else if (memWbHit && memWb.dest == idEx.rs)
			fwdA = fwdMemWb;
		if (exMemHit && exMem.dest == idEx.rt)
			fwdB = fwdExMem;
		else if (memWbHit && memWb.dest == idEx.rt)
			fwdB = fwdMemWb;
	end

endmodule

//--- hw/mipsPipeline.sv
`timescale 1ns/10ps

module mipsPipeline import mipsPkg::*; (
	input  logic    Clk,
	input  logic    rstN,
	input  logic    imemWe,
	input  wordT    imemAddr,
	input  wordT    imemData,
	output logic    wbValid,
	output regAddrT wbReg,
	output wordT    wbData,
	output logic    memWe,
	output wordT    memAddr,
	output wordT    memData
);

	ifIdT    ifId;
	idExT    idEx;
	exMemT   exMem;
	memWbT   memWb;
	logic    stall;
	logic    branchTaken;
	wordT    branchTarget;
	logic    jumpTaken;
	wordT    jumpTarget;
	regAddrT rsId;
	regAddrT rtId;
	fwdSelT  fwdA;
	fwdSelT  fwdB;

	fetchStage fetchStage_inst (
		.Clk (Clk), .rstN (rstN), .stall (stall),
		.branchTaken (branchTaken), .branchTarget (branchTarget),
		.jumpTaken (jumpTaken), .jumpTarget (jumpTarget),
		.imemWe (imemWe), .imemAddr (imemAddr), .imemData (imemData),
		.ifId (ifId)
	);

	decodeStage decodeStage_inst (
		.Clk (Clk), .rstN (rstN), .ifId (ifId), .stall (stall),
		.branchTaken (branchTaken), .memWb (memWb), .idEx (idEx),
		.jumpTaken (jumpTaken), .jumpTarget (jumpTarget),
		.rs (rsId), .rt (rtId)
	);

	executeStage executeStage_inst (
		.Clk (Clk), .rstN (rstN), .idEx (idEx), .fwdA (fwdA), .fwdB (fwdB),
		.exMemFwd (exMem.aluResult), .wbFwd (memWb.wData), .exMem (exMem),
		.branchTaken (branchTaken), .branchTarget (branchTarget)
	);

	memoryStage memoryStage_inst (
		.Clk (Clk), .rstN (rstN), .exMem (exMem), .memWb (memWb),
		.memWe (memWe), .memAddr (memAddr), .memData (memData)
	);

	hazardUnit hazardUnit_inst (
		.rsId (rsId), .rtId (rtId), .idEx (idEx), .exMem (exMem),
		.memWb (memWb), .stall (stall), .fwdA (fwdA), .fwdB (fwdB)
	);

	assign wbValid = memWb.regWrite && memWb.dest != '0; // r0 writes stay hidden
	assign wbReg   = memWb.dest;
	assign wbData  = memWb.wData;

endmodule

//--- sim/mipsPipelineTb.sv
`timescale 1ns/10ps

module mipsPipelineTb import mipsPkg::*; ();

	logic    Clk;
	logic    rstN;
	logic    imemWe;
	wordT    imemAddr;
	wordT    imemData;
	logic    wbValid;
	regAddrT wbReg;
	wordT    wbData;
	logic    memWe;
	wordT    memAddr;
	wordT    memData;

	int          errors = 0;
	int          cycles = 0;
	logic [31:0] seed = 32'h0a64_ac54;
	wordT        prog[$];
	logic [69:0] expected[$]; // {isStore, reg, addr, data}
	logic [69:0] events[$];

	mipsPipeline mipsPipeline_inst (
		.Clk (Clk), .rstN (rstN), .imemWe (imemWe), .imemAddr (imemAddr),
		.imemData (imemData), .wbValid (wbValid), .wbReg (wbReg), .wbData (wbData),
		.memWe (memWe), .memAddr (memAddr), .memData (memData)
	);

	always #4 Clk = ~Clk;

	always @(posedge Clk) begin
		cycles++;
		if (cycles >= 800) begin
			$display("Timeout: the run went past 800 cycles");
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic wordT rInstr(logic [5:0] fn, regAddrT rd, regAddrT rs, regAddrT rt);
		return {opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic wordT iInstr(logic [5:0] op, regAddrT rt, regAddrT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wordT jInstr(int index);
		return {opJ, 26'(index)}; // Word index of the target
	endfunction

	function automatic wordT signExt16(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [69:0] wbEvent(regAddrT r, wordT d);
		return {1'b0, r, 32'd0, d};
	endfunction

	function automatic logic [69:0] storeEvent(wordT a, wordT d);
		return {1'b1, 5'd0, a, d};
	endfunction

	// Sample at the falling edge where outputs are settled
	always @(negedge Clk) begin
		if (wbValid && wbReg == 5'd0) begin
			$display("ERROR %0t: write to register 0 reached writeback", $time);
			errors++;
		end
		if (wbValid)
			events.push_back(wbEvent(wbReg, wbData));
		if (memWe)
			events.push_back(storeEvent(memAddr, memData));
	end

	task automatic tick();
		@(posedge Clk);
		#1;
	endtask

	task automatic runProgram(input string name);
		int waited;
		int n;
		rstN = 1'b0;
		events.delete();
		for (int i = 0; i < 16; i++) begin
			imemWe   = (i < prog.size());
			imemAddr = i * 4;
			imemData = (i < prog.size()) ? prog[i] : 32'd0;
			tick();
		end
		imemWe = 1'b0;
		rstN   = 1'b1;
		repeat (3) begin // Nothing can retire before the fourth edge
			@(negedge Clk);
			if (wbValid || memWe) begin
				$display("ERROR %0t: %s retired an event too early after reset", $time, name);
				errors++;
			end
		end
		waited = 0;
		while (events.size() < expected.size() && waited < 100) begin
			@(posedge Clk);
			waited++;
		end
		repeat (6) @(posedge Clk); // Room for stray events
		#1;
		n = (events.size() < expected.size()) ? events.size() : expected.size();
		for (int i = 0; i < n; i++) begin
			if (events[i] !== expected[i]) begin
				$display("ERROR %0t: %s event %0d expected %h got %h",
					$time, name, i, expected[i], events[i]);
				errors++;
			end
		end
		if (events.size() < expected.size()) begin
			$display("%s: only %0d of %0d expected events were seen",
				name, events.size(), expected.size());
			errors++;
		end else if (events.size() > expected.size()) begin
			$display("%s: %0d events seen where %0d were expected",
				name, events.size(), expected.size());
			errors++;
		end
	endtask

	task automatic forwardChainTest();
		logic [31:0] r;
		logic [15:0] i1, i2, i3;
		wordT        v1, v2, v3, v4, v5, v6, v7, v8, v9;
		r  = nextRand();
		i1 = r[15:0];
		i2 = r[31:16];
		r  = nextRand();
		i3 = r[23:8] | 16'h8000; // Upper bit set to tell zero from sign extension
		v1 = signExt16(i1);
		v2 = signExt16(i2);
		v3 = v1 + v2;
		v4 = v2 - v3;
		v5 = v4 & v3;
		v6 = v5 | v2;
		v7 = ($signed(v6) < $signed(v4)) ? 32'd1 : 32'd0;
		v9 = ($signed(v4) < $signed(v6)) ? 32'd1 : 32'd0;
		v8 = v7 | {16'h0000, i3};
		prog = {iInstr(opAddi, 5'd1, 5'd0, i1), iInstr(opAddiu, 5'd2, 5'd0, i2),
			rInstr(fnAdd, 5'd3, 5'd1, 5'd2), rInstr(fnSub, 5'd4, 5'd2, 5'd3),
			rInstr(fnAnd, 5'd5, 5'd4, 5'd3), rInstr(fnOr, 5'd6, 5'd5, 5'd2),
			rInstr(fnSlt, 5'd7, 5'd6, 5'd4), rInstr(fnSlt, 5'd9, 5'd4, 5'd6),
			iInstr(opOri, 5'd8, 5'd7, i3), iInstr(opAddi, 5'd0, 5'd0, i3), jInstr(10)};
		expected = {wbEvent(5'd1, v1), wbEvent(5'd2, v2), wbEvent(5'd3, v3),
			wbEvent(5'd4, v4), wbEvent(5'd5, v5), wbEvent(5'd6, v6),
			wbEvent(5'd7, v7), wbEvent(5'd9, v9), wbEvent(5'd8, v8)};
		runProgram("forward chain");
	endtask

	task automatic loadStoreTest();
		logic [31:0] r;
		wordT        v1;
		r  = nextRand();
		v1 = signExt16(r[15:0]);
		prog = {iInstr(opAddi, 5'd1, 5'd0, r[15:0]), iInstr(opAddi, 5'd2, 5'd0, 16'h0020),
			iInstr(opSw, 5'd1, 5'd2, 16'd8), iInstr(opLw, 5'd3, 5'd2, 16'd8),
			rInstr(fnAdd, 5'd4, 5'd3, 5'd1), jInstr(5)};
		expected = {wbEvent(5'd1, v1), wbEvent(5'd2, 32'h20), storeEvent(32'h28, v1),
			wbEvent(5'd3, v1), wbEvent(5'd4, v1 + v1)};
		runProgram("load store");
	endtask

	task automatic branchTest();
		logic [31:0] r;
		logic [15:0] x, y;
		r = nextRand();
		x = r[15:0];
		y = x + 16'd1;
		// Taken branches land three words past themselves
		prog = {iInstr(opAddi, 5'd1, 5'd0, x), iInstr(opAddi, 5'd2, 5'd0, x),
			iInstr(opAddi, 5'd3, 5'd0, y), iInstr(opBeq, 5'd2, 5'd1, 16'd2),
			iInstr(opAddi, 5'd4, 5'd0, 16'd1), iInstr(opAddi, 5'd5, 5'd0, 16'd2),
			iInstr(opAddi, 5'd6, 5'd0, 16'd6), iInstr(opBeq, 5'd3, 5'd1, 16'd1),
			iInstr(opBne, 5'd3, 5'd1, 16'd2), iInstr(opAddi, 5'd4, 5'd0, 16'd3),
			iInstr(opAddi, 5'd5, 5'd0, 16'd4), iInstr(opAddi, 5'd7, 5'd0, 16'd7),
			iInstr(opBne, 5'd2, 5'd1, 16'd1), iInstr(opAddi, 5'd8, 5'd0, 16'd8),
			jInstr(14)};
		expected = {wbEvent(5'd1, signExt16(x)), wbEvent(5'd2, signExt16(x)),
			wbEvent(5'd3, signExt16(y)), wbEvent(5'd6, 32'd6), wbEvent(5'd7, 32'd7),
			wbEvent(5'd8, 32'd8)};
		runProgram("branch");
	endtask

	task automatic jumpTest();
		logic [31:0] r;
		r = nextRand();
		prog = {iInstr(opAddi, 5'd1, 5'd0, r[15:0]), jInstr(3),
			iInstr(opAddi, 5'd2, 5'd0, 16'd99), iInstr(opAddi, 5'd3, 5'd0, r[31:16]),
			jInstr(4)};
		expected = {wbEvent(5'd1, signExt16(r[15:0])), wbEvent(5'd3, signExt16(r[31:16]))};
		runProgram("jump");
	endtask

	initial begin
		Clk      = 1'b0;
		rstN     = 1'b0;
		imemWe   = 1'b0;
		imemAddr = '0;
		imemData = '0;
		tick();
		forwardChainTest();
		loadStoreTest();
		branchTest();
		jumpTest();
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- filelist.f
hw/mipsPkg.sv
hw/alu.sv
hw/registerFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/hazardUnit.sv
hw/mipsPipeline.sv
sim/mipsPipelineTb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f filelist.f --top-module mipsPipelineTb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
